// File: hw/rvv_lite_settings.svh
`ifndef RVV_LITE_SETTINGS_SVH
`define RVV_LITE_SETTINGS_SVH

// Element and register shape
`define RVV_ELEN       8
`define RVV_NUM_ELEM   4
`define RVV_VLEN       32

// Register file size
`define RVV_NUM_VREG   8
`define RVV_VREG_W     3

// Queue depths
`define RVV_CQ_DEPTH   4
`define RVV_UQ_DEPTH   4

// Reorder buffer
`define RVV_ROB_DEPTH  4
`define RVV_ROB_TAG_W  2

`endif

// File: hw/rvv_lite_inst_pkg.sv
`default_nettype none

`include "rvv_lite_settings.svh"

package rvv_lite_inst_pkg;

  // Vector opcodes handled by the backend
  typedef enum logic [1:0] {
    VOP_ADD   = 2'd0,
    VOP_SUB   = 2'd1,
    VOP_SADDU = 2'd2,
    VOP_MVX   = 2'd3
  } vop_e;

  // Instruction as pushed by the scalar core
  typedef struct packed {
    vop_e                   opcode;
    logic [`RVV_VREG_W-1:0] vd;
    logic [`RVV_VREG_W-1:0] vs1;
    logic [`RVV_VREG_W-1:0] vs2;
    logic [`RVV_ELEN-1:0]   scalar;
    // Register group of two
    logic                   lmul2;
  } vinst_t;

  // One micro-op, a single register wide
  typedef struct packed {
    vop_e                   opcode;
    logic [`RVV_VREG_W-1:0] vd;
    logic [`RVV_VREG_W-1:0] vs1;
    logic [`RVV_VREG_W-1:0] vs2;
    logic [`RVV_ELEN-1:0]   scalar;
    logic                   last_uop;
  } vuop_t;

endpackage

`default_nettype wire

// File: hw/rvv_lite_rob_pkg.sv
`default_nettype none

`include "rvv_lite_settings.svh"

package rvv_lite_rob_pkg;

  typedef logic [`RVV_ROB_TAG_W-1:0] rob_tag_t;

  // One reorder buffer slot
  typedef struct packed {
    logic                   valid;
    // Result written back, ready to retire
    logic                   done;
    logic [`RVV_VREG_W-1:0] vd;
    logic [`RVV_VLEN-1:0]   data;
    logic                   last_uop;
    logic                   vxsat;
  } rob_entry_t;

endpackage

`default_nettype wire

// File: hw/rvv_lite_fifo.sv
`default_nettype none

module rvv_lite_fifo import rvv_lite_inst_pkg::*; #(
  parameter type T     = vinst_t,
  parameter int  DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  push_i,
  input  wire  T push_data_i,
  input  wire  pop_i,
  output T     pop_data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  T            mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Head is always visible on the output
  assign pop_data_o = mem[rd_ptr];
  assign full_o     = (count == CW'(DEPTH));
  assign empty_o    = (count == '0);

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  // Callers must respect the flags
  assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o)
    else $error("push into full FIFO");
  assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// File: hw/rvv_lite_decode.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_decode import rvv_lite_inst_pkg::*; (
  input  wire    clk,
  input  wire    rst_n,
  input  wire    cq_empty_i,
  input  wire    vinst_t cq_inst_i,
  output logic   cq_pop_o,
  input  wire    uq_full_i,
  output logic   uq_push_o,
  output vuop_t  uq_uop_o
);

  // Set while the upper half of a register group is pending
  logic                   second_half;
  logic [`RVV_VREG_W-1:0] offset;

  assign offset    = {{(`RVV_VREG_W - 1){1'b0}}, second_half};
  assign uq_push_o = !cq_empty_i && !uq_full_i;
  // Instruction leaves the queue with its last micro-op
  assign cq_pop_o  = uq_push_o && (!cq_inst_i.lmul2 || second_half);

  always_comb begin
    uq_uop_o.opcode   = cq_inst_i.opcode;
    uq_uop_o.vd       = cq_inst_i.vd + offset;
    uq_uop_o.vs1      = cq_inst_i.vs1 + offset;
    uq_uop_o.vs2      = cq_inst_i.vs2 + offset;
    uq_uop_o.scalar   = cq_inst_i.scalar;
    uq_uop_o.last_uop = !cq_inst_i.lmul2 || second_half;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_half <= 1'b0;
    end else if (uq_push_o) begin
      second_half <= cq_inst_i.lmul2 && !second_half;
    end
  end

  // Group instruction stays at the queue head until its second half goes out
  assert property (@(posedge clk) disable iff (!rst_n)
    second_half |-> !cq_empty_i && cq_inst_i.lmul2)
    else $error("instruction popped before its last micro-op");

endmodule

`default_nettype wire

// File: hw/rvv_lite_alu.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_alu import rvv_lite_inst_pkg::*; import rvv_lite_rob_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          uq_empty_i,
  input  wire vuop_t                   uq_uop_i,
  output logic                         uq_pop_o,
  input  wire                          rob_full_i,
  input  wire [`RVV_NUM_VREG-1:0]      rob_busy_vreg_i,
  output logic                         alloc_valid_o,
  output logic [`RVV_VREG_W-1:0]       alloc_vd_o,
  output logic                         alloc_last_o,
  input  wire rob_tag_t                alloc_tag_i,
  output logic [`RVV_VREG_W-1:0]       vs1_addr_o,
  output logic [`RVV_VREG_W-1:0]       vs2_addr_o,
  input  wire [`RVV_VLEN-1:0]          vs1_data_i,
  input  wire [`RVV_VLEN-1:0]          vs2_data_i,
  output logic                         wb_valid_o,
  output rob_tag_t                     wb_tag_o,
  output logic [`RVV_VLEN-1:0]         wb_data_o,
  output logic                         wb_vxsat_o
);

  logic                 is_sat;
  logic                 issue;
  logic [`RVV_ELEN:0]   elem_sum [`RVV_NUM_ELEM];
  logic [`RVV_VLEN-1:0] res_data;
  logic                 res_vxsat;

  // One-cycle result stage
  logic                 one_valid;
  rob_tag_t             one_tag;
  logic [`RVV_VLEN-1:0] one_data;

  // Two-cycle pipe for saturating adds
  logic [1:0]           sat_valid;
  rob_tag_t             sat_tag   [2];
  logic [`RVV_VLEN-1:0] sat_data  [2];
  logic                 sat_vxsat [2];

  assign is_sat     = (uq_uop_i.opcode == VOP_SADDU);
  assign vs1_addr_o = uq_uop_i.vs1;
  assign vs2_addr_o = uq_uop_i.vs2;

  // A one-cycle op would meet the saturating op already in flight
  assign issue = !uq_empty_i && !rob_full_i &&
                 !rob_busy_vreg_i[uq_uop_i.vs1] && !rob_busy_vreg_i[uq_uop_i.vs2] &&
                 !(!is_sat && sat_valid[0]);

  assign uq_pop_o      = issue;
  assign alloc_valid_o = issue;
  assign alloc_vd_o    = uq_uop_i.vd;
  assign alloc_last_o  = uq_uop_i.last_uop;

  // Element ops, vs2 is the first operand as in RVV
  always_comb begin
    res_data  = '0;
    res_vxsat = 1'b0;
    for (int i = 0; i < `RVV_NUM_ELEM; i++) begin
      elem_sum[i] = {1'b0, vs2_data_i[i*`RVV_ELEN +: `RVV_ELEN]} +
                    {1'b0, vs1_data_i[i*`RVV_ELEN +: `RVV_ELEN]};
      case (uq_uop_i.opcode)
        VOP_ADD: res_data[i*`RVV_ELEN +: `RVV_ELEN] = elem_sum[i][`RVV_ELEN-1:0];
        VOP_SUB: res_data[i*`RVV_ELEN +: `RVV_ELEN] =
          vs2_data_i[i*`RVV_ELEN +: `RVV_ELEN] - vs1_data_i[i*`RVV_ELEN +: `RVV_ELEN];
        VOP_SADDU: begin
          res_data[i*`RVV_ELEN +: `RVV_ELEN] =
            elem_sum[i][`RVV_ELEN] ? '1 : elem_sum[i][`RVV_ELEN-1:0];
          res_vxsat = res_vxsat | elem_sum[i][`RVV_ELEN];
        end
        default: res_data[i*`RVV_ELEN +: `RVV_ELEN] = uq_uop_i.scalar;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      one_valid <= 1'b0;
      sat_valid <= 2'b00;
    end else begin
      one_valid <= issue && !is_sat;
      sat_valid <= {sat_valid[0], issue && is_sat};
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !is_sat) begin
      one_tag  <= alloc_tag_i;
      one_data <= res_data;
    end
    if (issue && is_sat) begin
      sat_tag[0]   <= alloc_tag_i;
      sat_data[0]  <= res_data;
      sat_vxsat[0] <= res_vxsat;
    end
    sat_tag[1]   <= sat_tag[0];
    sat_data[1]  <= sat_data[0];
    sat_vxsat[1] <= sat_vxsat[0];
  end

  assign wb_valid_o = one_valid || sat_valid[1];
  assign wb_tag_o   = sat_valid[1] ? sat_tag[1] : one_tag;
  assign wb_data_o  = sat_valid[1] ? sat_data[1] : one_data;
  assign wb_vxsat_o = sat_valid[1] && sat_vxsat[1];

  // Issue hold keeps the writeback port free of conflicts
  assert property (@(posedge clk) disable iff (!rst_n) !(one_valid && sat_valid[1]))
    else $error("two writebacks in one cycle");

endmodule

`default_nettype wire

// File: hw/rvv_lite_rob.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_rob import rvv_lite_rob_pkg::*; (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        alloc_valid_i,
  input  wire [`RVV_VREG_W-1:0]      alloc_vd_i,
  input  wire                        alloc_last_i,
  output rob_tag_t                   alloc_tag_o,
  output logic                       full_o,
  output logic [`RVV_NUM_VREG-1:0]   busy_vreg_o,
  input  wire                        wb_valid_i,
  input  wire rob_tag_t              wb_tag_i,
  input  wire [`RVV_VLEN-1:0]        wb_data_i,
  input  wire                        wb_vxsat_i,
  output logic                       rt_valid_o,
  input  wire                        rt_ready_i,
  output logic [`RVV_VREG_W-1:0]     rt_vd_o,
  output logic [`RVV_VLEN-1:0]       rt_data_o,
  output logic                       rt_last_o,
  output logic                       rt_vxsat_o,
  output logic                       vrf_we_o
);

  rob_entry_t                 entries [`RVV_ROB_DEPTH];
  rob_tag_t                   head;
  rob_tag_t                   tail;
  logic [`RVV_ROB_TAG_W:0]    count;
  logic                       retire;

  assign alloc_tag_o = tail;
  assign full_o      = (count == `RVV_ROB_DEPTH);

  // Head entry drives the retire port
  assign rt_valid_o = entries[head].valid && entries[head].done;
  assign rt_vd_o    = entries[head].vd;
  assign rt_data_o  = entries[head].data;
  assign rt_last_o  = entries[head].last_uop;
  assign rt_vxsat_o = entries[head].vxsat;
  assign retire     = rt_valid_o && rt_ready_i;
  assign vrf_we_o   = retire;

  // Destinations not yet in the register file
  always_comb begin
    busy_vreg_o = '0;
    for (int i = 0; i < `RVV_ROB_DEPTH; i++) begin
      if (entries[i].valid) begin
        busy_vreg_o[entries[i].vd] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entries <= '{default: '0};
      head    <= '0;
      tail    <= '0;
      count   <= '0;
    end else begin
      if (alloc_valid_i) begin
        entries[tail] <= '{valid: 1'b1, done: 1'b0, vd: alloc_vd_i, data: '0,
                           last_uop: alloc_last_i, vxsat: 1'b0};
        tail <= tail + 1'b1;
      end
      // Writeback may land in any order
      if (wb_valid_i) begin
        entries[wb_tag_i].done  <= 1'b1;
        entries[wb_tag_i].data  <= wb_data_i;
        entries[wb_tag_i].vxsat <= wb_vxsat_i;
      end
      if (retire) begin
        entries[head].valid <= 1'b0;
        head <= head + 1'b1;
      end
      if (alloc_valid_i && !retire) begin
        count <= count + 1'b1;
      end else if (retire && !alloc_valid_i) begin
        count <= count - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_i |-> entries[wb_tag_i].valid && !entries[wb_tag_i].done)
    else $error("writeback to a free or finished entry");
  assert property (@(posedge clk) disable iff (!rst_n) alloc_valid_i |-> !full_o)
    else $error("allocation into full ROB");

endmodule

`default_nettype wire

// File: hw/rvv_lite_vrf.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_vrf (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire [`RVV_VREG_W-1:0]   rd1_addr_i,
  output logic [`RVV_VLEN-1:0]    rd1_data_o,
  input  wire [`RVV_VREG_W-1:0]   rd2_addr_i,
  output logic [`RVV_VLEN-1:0]    rd2_data_o,
  input  wire [`RVV_VREG_W-1:0]   rd3_addr_i,
  output logic [`RVV_VLEN-1:0]    rd3_data_o,
  input  wire                     we_i,
  input  wire [`RVV_VREG_W-1:0]   waddr_i,
  input  wire [`RVV_VLEN-1:0]     wdata_i
);

  logic [`RVV_VLEN-1:0] regs [`RVV_NUM_VREG];

  // Combinational reads, no bypass of the write in flight
  assign rd1_data_o = regs[rd1_addr_i];
  assign rd2_data_o = regs[rd2_addr_i];
  assign rd3_data_o = regs[rd3_addr_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/rvv_lite_backend.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_backend import rvv_lite_inst_pkg::*; import rvv_lite_rob_pkg::*; (
  input  wire                      clk,
  input  wire                      rst_n,
  // Instruction input
  input  wire                      inst_valid_i,
  output logic                     inst_ready_o,
  input  wire vop_e                inst_op_i,
  input  wire [`RVV_VREG_W-1:0]    inst_vd_i,
  input  wire [`RVV_VREG_W-1:0]    inst_vs1_i,
  input  wire [`RVV_VREG_W-1:0]    inst_vs2_i,
  input  wire [`RVV_ELEN-1:0]      inst_scalar_i,
  input  wire                      inst_lmul2_i,
  // Retire output
  output logic                     rt_valid_o,
  input  wire                      rt_ready_i,
  output logic [`RVV_VREG_W-1:0]   rt_vd_o,
  output logic [`RVV_VLEN-1:0]     rt_data_o,
  output logic                     rt_last_o,
  output logic                     rt_vxsat_o,
  // Test read port
  input  wire [`RVV_VREG_W-1:0]    test_raddr_i,
  output logic [`RVV_VLEN-1:0]     test_rdata_o
);

  vinst_t                   cq_in;
  vinst_t                   cq_inst;
  logic                     cq_full;
  logic                     cq_empty;
  logic                     cq_pop;
  vuop_t                    uq_in;
  vuop_t                    uq_uop;
  logic                     uq_push;
  logic                     uq_full;
  logic                     uq_empty;
  logic                     uq_pop;
  logic                     rob_full;
  logic [`RVV_NUM_VREG-1:0] rob_busy;
  logic                     alloc_valid;
  logic [`RVV_VREG_W-1:0]   alloc_vd;
  logic                     alloc_last;
  rob_tag_t                 alloc_tag;
  logic [`RVV_VREG_W-1:0]   vs1_addr;
  logic [`RVV_VREG_W-1:0]   vs2_addr;
  logic [`RVV_VLEN-1:0]     vs1_data;
  logic [`RVV_VLEN-1:0]     vs2_data;
  logic                     wb_valid;
  rob_tag_t                 wb_tag;
  logic [`RVV_VLEN-1:0]     wb_data;
  logic                     wb_vxsat;
  logic                     vrf_we;

  assign inst_ready_o = !cq_full;
  assign cq_in = '{opcode: inst_op_i, vd: inst_vd_i, vs1: inst_vs1_i, vs2: inst_vs2_i,
                   scalar: inst_scalar_i, lmul2: inst_lmul2_i};

  rvv_lite_fifo #(.T(vinst_t), .DEPTH(`RVV_CQ_DEPTH)) u_command_queue (
    .clk, .rst_n,
    .push_i(inst_valid_i && inst_ready_o), .push_data_i(cq_in),
    .pop_i(cq_pop), .pop_data_o(cq_inst),
    .full_o(cq_full), .empty_o(cq_empty)
  );

  rvv_lite_decode u_decode (
    .clk, .rst_n,
    .cq_empty_i(cq_empty), .cq_inst_i(cq_inst), .cq_pop_o(cq_pop),
    .uq_full_i(uq_full), .uq_push_o(uq_push), .uq_uop_o(uq_in)
  );

  rvv_lite_fifo #(.T(vuop_t), .DEPTH(`RVV_UQ_DEPTH)) u_uop_queue (
    .clk, .rst_n,
    .push_i(uq_push), .push_data_i(uq_in),
    .pop_i(uq_pop), .pop_data_o(uq_uop),
    .full_o(uq_full), .empty_o(uq_empty)
  );

  rvv_lite_alu u_alu (
    .clk, .rst_n,
    .uq_empty_i(uq_empty), .uq_uop_i(uq_uop), .uq_pop_o(uq_pop),
    .rob_full_i(rob_full), .rob_busy_vreg_i(rob_busy),
    .alloc_valid_o(alloc_valid), .alloc_vd_o(alloc_vd), .alloc_last_o(alloc_last),
    .alloc_tag_i(alloc_tag),
    .vs1_addr_o(vs1_addr), .vs2_addr_o(vs2_addr),
    .vs1_data_i(vs1_data), .vs2_data_i(vs2_data),
    .wb_valid_o(wb_valid), .wb_tag_o(wb_tag), .wb_data_o(wb_data), .wb_vxsat_o(wb_vxsat)
  );

  rvv_lite_rob u_rob (
    .clk, .rst_n,
    .alloc_valid_i(alloc_valid), .alloc_vd_i(alloc_vd), .alloc_last_i(alloc_last),
    .alloc_tag_o(alloc_tag), .full_o(rob_full), .busy_vreg_o(rob_busy),
    .wb_valid_i(wb_valid), .wb_tag_i(wb_tag), .wb_data_i(wb_data), .wb_vxsat_i(wb_vxsat),
    .rt_valid_o, .rt_ready_i, .rt_vd_o, .rt_data_o, .rt_last_o, .rt_vxsat_o,
    .vrf_we_o(vrf_we)
  );

  rvv_lite_vrf u_vrf (
    .clk, .rst_n,
    .rd1_addr_i(vs1_addr), .rd1_data_o(vs1_data),
    .rd2_addr_i(vs2_addr), .rd2_data_o(vs2_data),
    .rd3_addr_i(test_raddr_i), .rd3_data_o(test_rdata_o),
    .we_i(vrf_we), .waddr_i(rt_vd_o), .wdata_i(rt_data_o)
  );

endmodule

`default_nettype wire

// File: bench/rvv_lite_tb.sv
`default_nettype none

`include "rvv_lite_settings.svh"

module rvv_lite_tb import rvv_lite_inst_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_INST   = 14 + 6 + 16 + 40;
  localparam int MAX_UOPS   = 2 * NUM_INST;
  localparam int MAX_CYCLES = 20 * MAX_UOPS + 200;
  localparam int READY_ON     = 0;
  localparam int READY_HOLD   = 1;
  localparam int READY_RANDOM = 2;

  logic                     clk;
  logic                     rst_n;
  logic                     inst_valid_i;
  logic                     inst_ready_o;
  vop_e                     inst_op_i;
  logic [`RVV_VREG_W-1:0]   inst_vd_i;
  logic [`RVV_VREG_W-1:0]   inst_vs1_i;
  logic [`RVV_VREG_W-1:0]   inst_vs2_i;
  logic [`RVV_ELEN-1:0]     inst_scalar_i;
  logic                     inst_lmul2_i;
  logic                     rt_valid_o;
  logic                     rt_ready_i;
  logic [`RVV_VREG_W-1:0]   rt_vd_o;
  logic [`RVV_VLEN-1:0]     rt_data_o;
  logic                     rt_last_o;
  logic                     rt_vxsat_o;
  logic [`RVV_VREG_W-1:0]   test_raddr_i;
  logic [`RVV_VLEN-1:0]     test_rdata_o;

  // Reference register file and expected retire records in program order
  logic [`RVV_VLEN-1:0]     model_vreg [`RVV_NUM_VREG];
  logic [`RVV_VREG_W-1:0]   exp_vd     [MAX_UOPS];
  logic [`RVV_VLEN-1:0]     exp_data   [MAX_UOPS];
  logic                     exp_last   [MAX_UOPS];
  logic                     exp_vxsat  [MAX_UOPS];
  int                       exp_wr = 0;
  int                       rt_count = 0;
  int                       sent_uops = 0;
  int                       cycles = 0;
  int                       ready_mode = READY_ON;
  logic [31:0]              stim_state;
  logic [31:0]              stall_state;
  logic [`RVV_VREG_W-1:0]   head_vd;
  logic [`RVV_VLEN-1:0]     head_data;
  logic                     head_last;
  logic                     head_vxsat;
  logic                     retire;
  logic                     stalled_q = 1'b0;
  logic [`RVV_VREG_W-1:0]   held_vd;
  logic [`RVV_VLEN-1:0]     held_data;
  logic                     held_last;
  logic                     held_vxsat;

  rvv_lite_backend uut (
    .clk, .rst_n,
    .inst_valid_i, .inst_ready_o, .inst_op_i, .inst_vd_i, .inst_vs1_i, .inst_vs2_i,
    .inst_scalar_i, .inst_lmul2_i,
    .rt_valid_o, .rt_ready_i, .rt_vd_o, .rt_data_o, .rt_last_o, .rt_vxsat_o,
    .test_raddr_i, .test_rdata_o
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  // Element rules: wrapping add and sub, clamped unsigned add, scalar broadcast
  task automatic model_uop(input vop_e op, input logic [`RVV_VREG_W-1:0] vd,
                           input logic [`RVV_VREG_W-1:0] vs1,
                           input logic [`RVV_VREG_W-1:0] vs2,
                           input logic [`RVV_ELEN-1:0] scalar, input logic last);
    logic [`RVV_VLEN-1:0] res;
    logic                 sat;
    int                   a;
    int                   b;
    int                   s;
    res = '0;
    sat = 1'b0;
    for (int e = 0; e < `RVV_NUM_ELEM; e++) begin
      a = model_vreg[vs2][e*`RVV_ELEN +: `RVV_ELEN];
      b = model_vreg[vs1][e*`RVV_ELEN +: `RVV_ELEN];
      case (op)
        VOP_ADD: s = (a + b) % 256;
        VOP_SUB: s = (a - b + 256) % 256;
        VOP_SADDU: begin
          s = a + b;
          if (s > 255) begin
            s = 255;
            sat = 1'b1;
          end
        end
        default: s = scalar;
      endcase
      res[e*`RVV_ELEN +: `RVV_ELEN] = s[`RVV_ELEN-1:0];
    end
    model_vreg[vd] = res;
    exp_vd[exp_wr] = vd;
    exp_data[exp_wr] = res;
    exp_last[exp_wr] = last;
    exp_vxsat[exp_wr] = sat;
    exp_wr++;
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_inst(input vop_e op, input logic [`RVV_VREG_W-1:0] vd,
                           input logic [`RVV_VREG_W-1:0] vs1,
                           input logic [`RVV_VREG_W-1:0] vs2,
                           input logic [`RVV_ELEN-1:0] scalar, input logic lmul2);
    inst_valid_i = 1'b1;
    inst_op_i = op;
    inst_vd_i = vd;
    inst_vs1_i = vs1;
    inst_vs2_i = vs2;
    inst_scalar_i = scalar;
    inst_lmul2_i = lmul2;
    while (!inst_ready_o) @(negedge clk);
    @(negedge clk);
    sent_uops += lmul2 ? 2 : 1;
  endtask

  task automatic send_random();
    logic [31:0] r;
    stim_state = lcg_next(stim_state);
    r = stim_state;
    send_inst(vop_e'(r[31:30]), r[29:27], r[26:24], r[23:21], r[20:13], r[12:11] == 2'b11);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Retire port stall pattern
  always @(negedge clk) begin
    stall_state = lcg_next(stall_state);
    case (ready_mode)
      READY_HOLD: rt_ready_i = 1'b0;
      READY_RANDOM: rt_ready_i = (stall_state[31:30] != 2'b00);
      default: rt_ready_i = 1'b1;
    endcase
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst_n && inst_valid_i && inst_ready_o) begin
      if (inst_lmul2_i) begin
        model_uop(inst_op_i, inst_vd_i, inst_vs1_i, inst_vs2_i, inst_scalar_i, 1'b0);
        model_uop(inst_op_i, inst_vd_i + 1'b1, inst_vs1_i + 1'b1, inst_vs2_i + 1'b1,
                  inst_scalar_i, 1'b1);
      end else begin
        model_uop(inst_op_i, inst_vd_i, inst_vs1_i, inst_vs2_i, inst_scalar_i, 1'b1);
      end
    end
    if (rst_n && retire) begin
      rt_count <= rt_count + 1;
    end
    stalled_q  <= rst_n && rt_valid_o && !rt_ready_i;
    held_vd    <= rt_vd_o;
    held_data  <= rt_data_o;
    held_last  <= rt_last_o;
    held_vxsat <= rt_vxsat_o;
  end

  assign retire     = rt_valid_o && rt_ready_i;
  assign head_vd    = exp_vd[rt_count];
  assign head_data  = exp_data[rt_count];
  assign head_last  = exp_last[rt_count];
  assign head_vxsat = exp_vxsat[rt_count];

  assert property (@(posedge clk) disable iff (!rst_n) retire |-> rt_count < exp_wr)
    else report_error("a micro-op retired with no instruction left to account for it");
  assert property (@(posedge clk) disable iff (!rst_n) retire |-> rt_vd_o == head_vd)
    else report_error($sformatf("CHECK FAILED rt_vd_o: got %h, expected %h",
                                $sampled(rt_vd_o), $sampled(head_vd)));
  assert property (@(posedge clk) disable iff (!rst_n) retire |-> rt_data_o == head_data)
    else report_error($sformatf("CHECK FAILED rt_data_o: got %h, expected %h",
                                $sampled(rt_data_o), $sampled(head_data)));
  assert property (@(posedge clk) disable iff (!rst_n) retire |-> rt_last_o == head_last)
    else report_error($sformatf("CHECK FAILED rt_last_o: got %h, expected %h",
                                $sampled(rt_last_o), $sampled(head_last)));
  assert property (@(posedge clk) disable iff (!rst_n) retire |-> rt_vxsat_o == head_vxsat)
    else report_error($sformatf("CHECK FAILED rt_vxsat_o: got %h, expected %h",
                                $sampled(rt_vxsat_o), $sampled(head_vxsat)));

  // Head must hold while the retire port is stalled
  assert property (@(posedge clk) disable iff (!rst_n) stalled_q |-> rt_valid_o)
    else report_error($sformatf("CHECK FAILED rt_valid_o: got %h, expected %h",
                                $sampled(rt_valid_o), 1'b1));
  assert property (@(posedge clk) disable iff (!rst_n) stalled_q |-> rt_vd_o == held_vd)
    else report_error($sformatf("CHECK FAILED rt_vd_o: got %h, expected %h",
                                $sampled(rt_vd_o), $sampled(held_vd)));
  assert property (@(posedge clk) disable iff (!rst_n) stalled_q |-> rt_data_o == held_data)
    else report_error($sformatf("CHECK FAILED rt_data_o: got %h, expected %h",
                                $sampled(rt_data_o), $sampled(held_data)));
  assert property (@(posedge clk) disable iff (!rst_n) stalled_q |-> rt_last_o == held_last)
    else report_error($sformatf("CHECK FAILED rt_last_o: got %h, expected %h",
                                $sampled(rt_last_o), $sampled(held_last)));
  assert property (@(posedge clk) disable iff (!rst_n)
    stalled_q |-> rt_vxsat_o == held_vxsat)
    else report_error($sformatf("CHECK FAILED rt_vxsat_o: got %h, expected %h",
                                $sampled(rt_vxsat_o), $sampled(held_vxsat)));

  initial begin
    wait (cycles >= MAX_CYCLES);
    report_error($sformatf("timeout: not all micro-ops retired within %0d cycles",
                           MAX_CYCLES));
  end

  initial begin
    logic [`RVV_ELEN-1:0] sc;
    int                   n;
    rst_n = 1'b0;
    inst_valid_i = 1'b0;
    inst_op_i = VOP_ADD;
    inst_vd_i = '0;
    inst_vs1_i = '0;
    inst_vs2_i = '0;
    inst_scalar_i = '0;
    inst_lmul2_i = 1'b0;
    rt_ready_i = 1'b1;
    test_raddr_i = '0;
    stim_state = 32'h4418d1fc;
    stall_state = lcg_next(32'h4418d1fc);
    for (int r = 0; r < `RVV_NUM_VREG; r++) begin
      model_vreg[r] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    assert (!rt_valid_o)
      else report_error($sformatf("CHECK FAILED rt_valid_o: got %h, expected %h",
                                  rt_valid_o, 1'b0));
    assert (inst_ready_o)
      else report_error($sformatf("CHECK FAILED inst_ready_o: got %h, expected %h",
                                  inst_ready_o, 1'b1));
    for (int r = 0; r < `RVV_NUM_VREG; r++) begin
      @(negedge clk);
      test_raddr_i = r[`RVV_VREG_W-1:0];
      #1;
      assert (test_rdata_o == '0)
        else report_error($sformatf("CHECK FAILED test_rdata_o: got %h, expected %h",
                                    test_rdata_o, 32'h0));
    end
    @(negedge clk);

    // Broadcast seeds, then saturating adds mixed with moves and register groups
    sc = 8'h41;
    for (int r = 0; r < `RVV_NUM_VREG; r++) begin
      send_inst(VOP_MVX, r[`RVV_VREG_W-1:0], 3'd0, 3'd0, sc, 1'b0);
      sc = sc + 8'h3b;
    end
    send_inst(VOP_SADDU, 3'd1, 3'd3, 3'd2, 8'h00, 1'b0);
    send_inst(VOP_MVX, 3'd4, 3'd0, 3'd0, 8'h5a, 1'b0);
    send_inst(VOP_SADDU, 3'd5, 3'd4, 3'd0, 8'h00, 1'b0);
    send_inst(VOP_MVX, 3'd6, 3'd0, 3'd0, 8'hc3, 1'b0);
    send_inst(VOP_ADD, 3'd2, 3'd4, 3'd6, 8'h00, 1'b1);
    // Group of two wraps from v7 to v0
    send_inst(VOP_SUB, 3'd7, 3'd1, 3'd2, 8'h00, 1'b1);

    // Read-after-write chain
    for (int i = 0; i < 6; i++) begin
      send_inst(vop_e'(i % 3), 3'(i + 1), 3'(i), 3'(i), 8'h00, 1'b0);
    end

    // Long retire stall until the command queue backs up
    ready_mode = READY_HOLD;
    n = 0;
    while (inst_ready_o && n < 16) begin
      send_random();
      n++;
    end
    inst_valid_i = 1'b0;
    assert (!inst_ready_o)
      else report_error("inst_ready_o never went low while retire was stalled");
    repeat (20) @(negedge clk);
    ready_mode = READY_RANDOM;

    for (int i = 0; i < 40; i++) begin
      send_random();
    end
    inst_valid_i = 1'b0;
    ready_mode = READY_ON;

    while (rt_count != sent_uops) @(negedge clk);
    repeat (10) @(negedge clk);
    assert (rt_count == sent_uops)
      else report_error($sformatf("CHECK FAILED rt_count: got %h, expected %h",
                                  rt_count, sent_uops));
    assert (exp_wr == sent_uops)
      else report_error("the reference model missed some accepted micro-ops");
    for (int r = 0; r < `RVV_NUM_VREG; r++) begin
      @(negedge clk);
      test_raddr_i = r[`RVV_VREG_W-1:0];
      #1;
      assert (test_rdata_o == model_vreg[r])
        else report_error($sformatf("CHECK FAILED test_rdata_o: got %h, expected %h",
                                    test_rdata_o, model_vreg[r]));
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/rvv_lite_inst_pkg.sv
hw/rvv_lite_rob_pkg.sv
hw/rvv_lite_fifo.sv
hw/rvv_lite_decode.sv
hw/rvv_lite_alu.sv
hw/rvv_lite_rob.sv
hw/rvv_lite_vrf.sv
hw/rvv_lite_backend.sv
bench/rvv_lite_tb.sv
